//--- verilog.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/bram.sv
verilog/wb_cache_port.sv
verilog/cache_core.sv
verilog/burst_sequencer.sv
verilog/cache_top.sv
verification/burst_ram_model.sv
verification/tb_cache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --x-initial 0 --top-module tb_cache -f verilog.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_cache > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0

//--- verification/tb_cache.sv
// testbench for the write-back cache against a burst RAM model and a shadow memory
`timescale 1ns/100ps
`include "cache_settings.svh"

module tb_cache
  import cache_pkg::*;
();

  localparam logic [63:0] PATTERN     = 64'h5a3c_96e1_0f78_c3a5;
  localparam logic [31:0] SEED        = 32'h154dc2d2;
  localparam int unsigned IDX_BITS    = `CACHE_LINE_INDEX_BITS;
  localparam int unsigned ACK_TIMEOUT = 200;

  // one issued transfer and the word a read must return
  typedef struct packed {
    logic        rd;
    logic [31:0] adr;
    logic [31:0] data;
  } expect_t;

  logic                            clk;
  logic                            rst_n;
  logic                            cyc;
  logic                            stb;
  logic                            we;
  logic [31:0]                     adr;
  logic [31:0]                     dat_w;
  logic [3:0]                      sel;
  logic [31:0]                     dat_r;
  logic                            ack;
  br_cmd_t                         cmd;
  logic [63:0]                     rd_data;
  logic                            rd_data_valid;
  logic                            ram_err;
  int                              wr_count;
  logic [`CACHE_RAM_ADDR_BITS-1:0] wr_addr;
  line_data_t                      wr_line;

  logic [31:0] lfsr;
  logic [31:0] shadow [logic [29:0]];
  expect_t     exp_q [$];

  cache_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .cyc           (cyc),
    .stb           (stb),
    .we            (we),
    .adr           (adr),
    .dat_w         (dat_w),
    .sel           (sel),
    .dat_r         (dat_r),
    .ack           (ack),
    .cmd           (cmd),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid)
  );

  burst_ram_model #(
    .pattern(PATTERN)
  ) u_ram (
    .clk           (clk),
    .cmd           (cmd),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .err           (ram_err),
    .wr_count      (wr_count),
    .wr_addr       (wr_addr),
    .wr_line       (wr_line)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [31:0] a,
                            input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s at %h got %h expected %h", name, a, got, exp);
      abort_run();
    end
  endtask

  task automatic check_ram_addr(input logic [`CACHE_RAM_ADDR_BITS-1:0] got,
                                input logic [`CACHE_RAM_ADDR_BITS-1:0] exp);
    if (got !== exp) begin
      $display("FAIL cmd.addr got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  // 32 bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // expected word from the shadow memory or else the RAM fill pattern
  function automatic logic [31:0] ref_word(input logic [31:0] a);
    logic [63:0] pat;
    if (shadow.exists(a[31:2])) begin
      return shadow[a[31:2]];
    end
    pat = 64'(a[`CACHE_RAM_ADDR_BITS-1:3]) ^ PATTERN;
    return a[2] ? pat[63:32] : pat[31:0];
  endfunction

  task automatic shadow_write(input logic [31:0] a, input logic [31:0] d,
                              input logic [3:0] s);
    logic [31:0] w;
    w = ref_word(a);
    for (int i = 0; i < 4; i++) begin
      if (s[i]) begin
        w[8*i +: 8] = d[8*i +: 8];
      end
    end
    shadow[a[31:2]] = w;
  endtask

  function automatic logic [31:0] make_adr(input int unsigned tag, input int unsigned idx,
                                           input int unsigned col);
    return 32'((tag << (IDX_BITS + 5)) | (idx << 5) | (col << 2));
  endfunction

  // one Wishbone classic transfer followed by one idle cycle with stb low
  task automatic bus_xfer(input logic wr, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] s);
    expect_t e;
    int      n;
    e.rd   = !wr;
    e.adr  = a;
    e.data = ref_word(a);
    exp_q.push_back(e);
    if (wr) begin
      shadow_write(a, d, s);
    end
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    adr   = a;
    dat_w = d;
    sel   = s;
    n     = 0;
    @(negedge clk);
    while (!ack) begin
      n++;
      if (n >= ACK_TIMEOUT) begin
        $display("no ack within %0d cycles for address %h", ACK_TIMEOUT, a);
        abort_run();
      end
      @(negedge clk);
    end
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    @(negedge clk);
  endtask

  // every ack retires the oldest transfer and a read compares dat_r
  always @(negedge clk) begin : compare
    expect_t cur;
    if (rst_n && ack) begin
      if (exp_q.size() == 0) begin
        $display("ack seen with no transfer pending");
        abort_run();
      end else begin
        cur = exp_q.pop_front();
        if (cur.rd) begin
          check_data("dat_r", cur.adr, dat_r, cur.data);
        end
      end
    end
  end

  always @(posedge clk) begin
    if (ram_err) begin
      abort_run();
    end
  end

  initial begin
    int          wb_before;
    logic [31:0] victim;
    logic [31:0] r;
    logic [31:0] a;
    rst_n = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    sel   = '0;
    lfsr  = SEED;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // cold miss followed by a second word of the same line
    bus_xfer(1'b0, make_adr(1, 3, 2), '0, 4'hf);
    bus_xfer(1'b0, make_adr(1, 3, 5), '0, 4'hf);

    // partial byte writes merge with the old bytes
    bus_xfer(1'b1, make_adr(1, 3, 2), 32'hdead_beef, 4'b0001);
    bus_xfer(1'b1, make_adr(1, 3, 2), 32'h1234_5678, 4'b0110);
    bus_xfer(1'b1, make_adr(1, 3, 5), 32'hcafe_f00d, 4'b1000);
    bus_xfer(1'b0, make_adr(1, 3, 2), '0, 4'hf);
    bus_xfer(1'b0, make_adr(1, 3, 5), '0, 4'hf);

    // conflicting tag forces a write-back of the dirty line
    bus_xfer(1'b1, make_adr(1, 3, 7), 32'h0bad_c0de, 4'hf);
    wb_before = wr_count;
    bus_xfer(1'b0, make_adr(2, 3, 0), '0, 4'hf);
    if (wr_count != wb_before + 1) begin
      $display("expected one line write-back, saw %0d", wr_count - wb_before);
      abort_run();
    end
    victim = make_adr(1, 3, 0);
    check_ram_addr(wr_addr, victim[`CACHE_RAM_ADDR_BITS-1:0]);
    for (int c = 0; c < 8; c++) begin
      a = make_adr(1, 3, c);
      check_data("wr_data", a, wr_line[c], ref_word(a));
    end
    bus_xfer(1'b0, make_adr(1, 3, 2), '0, 4'hf);
    bus_xfer(1'b0, make_adr(1, 3, 7), '0, 4'hf);

    // random traffic over four tags that share every index
    for (int n = 0; n < 300; n++) begin
      a = make_adr(4 + take_bits(2), take_bits(IDX_BITS), take_bits(3));
      r = take_bits(1);
      bus_xfer(r[0], a, take_bits(32), 4'(take_bits(4)));
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- verification/burst_ram_model.sv
// behavioral burst pseudo-static RAM that answers commands and checks their spacing
`timescale 1ns/100ps
`include "cache_settings.svh"

module burst_ram_model
  import cache_pkg::*;
#(
  parameter logic [63:0] pattern = 64'h0
) (
  input  logic                            clk,
  input  br_cmd_t                         cmd,
  output logic [63:0]                     rd_data,
  output logic                            rd_data_valid,
  output logic                            err,
  output int                              wr_count,
  output logic [`CACHE_RAM_ADDR_BITS-1:0] wr_addr,
  output line_data_t                      wr_line
);

  localparam int unsigned WORD_BITS    = `CACHE_RAM_ADDR_BITS - 3;
  localparam int unsigned READ_LATENCY = 3;

  // written 64 bit words, everything else reads as the fill pattern
  logic [63:0]          mem [logic [WORD_BITS-1:0]];
  logic [WORD_BITS-1:0] rd_ptr;
  logic [WORD_BITS-1:0] wr_ptr;
  int                   rd_left;
  int                   rd_wait;
  int                   wr_beat;
  int                   cycle;
  int                   last_cmd;

  function automatic logic [63:0] load(input logic [WORD_BITS-1:0] w);
    if (mem.exists(w)) begin
      return mem[w];
    end
    return 64'(w) ^ pattern;
  endfunction

  initial begin
    rd_data       = '0;
    rd_data_valid = 1'b0;
    err           = 1'b0;
    wr_count      = 0;
    wr_addr       = '0;
    wr_line       = '0;
    rd_left       = 0;
    rd_wait       = 0;
    wr_beat       = 0;
    cycle         = 0;
    // far enough back that the first command is never too close
    last_cmd      = -100;
  end

  // outputs change on the falling edge, away from the sampling edge
  always @(negedge clk) begin
    cycle++;
    rd_data_valid = 1'b0;
    if (rd_left > 0) begin
      if (rd_wait > 0) begin
        rd_wait--;
      end else begin
        rd_data       = load(rd_ptr);
        rd_data_valid = 1'b1;
        rd_ptr++;
        rd_left--;
      end
    end

    // write beats 1 to 3 follow the command on consecutive cycles
    if (wr_beat > 0) begin
      mem[wr_ptr]          = cmd.wr_data;
      wr_line[2*wr_beat]   = cmd.wr_data[31:0];
      wr_line[2*wr_beat+1] = cmd.wr_data[63:32];
      wr_ptr++;
      if (wr_beat == 3) begin
        wr_beat = 0;
        wr_count++;
      end else begin
        wr_beat++;
      end
    end

    if (cmd.en) begin
      if (cycle - last_cmd < `CACHE_CMD_INTERVAL + 1) begin
        $display("burst RAM: command only %0d cycles after the previous one",
                 cycle - last_cmd);
        err = 1'b1;
      end
      last_cmd = cycle;
      if (cmd.we) begin
        if (cmd.mask != '0) begin
          $display("burst RAM: write command carries a nonzero data mask %h", cmd.mask);
          err = 1'b1;
        end
        wr_addr     = cmd.addr;
        wr_ptr      = cmd.addr[`CACHE_RAM_ADDR_BITS-1:3];
        mem[wr_ptr] = cmd.wr_data;
        wr_line[0]  = cmd.wr_data[31:0];
        wr_line[1]  = cmd.wr_data[63:32];
        wr_ptr++;
        wr_beat     = 1;
      end else begin
        rd_ptr  = cmd.addr[`CACHE_RAM_ADDR_BITS-1:3];
        rd_left = 4;
        rd_wait = READ_LATENCY;
      end
    end
  end

endmodule

//--- verilog/cache_top.sv
// write-back cache between a Wishbone slave port and a burst pseudo-static RAM
`timescale 1ns/100ps

module cache_top
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [31:0] adr,
  input  logic [31:0] dat_w,
  input  logic [3:0]  sel,
  output logic [31:0] dat_r,
  output logic        ack,
  output br_cmd_t     cmd,
  input  logic [63:0] rd_data,
  input  logic        rd_data_valid
);

  cache_req_t  req;
  logic        hit;
  logic [31:0] rd_word;
  logic        miss_start;
  miss_req_t   miss;
  line_data_t  line;
  fill_beat_t  fill;
  logic        fill_done;

  wb_cache_port u_port (
    .clk     (clk),
    .rst_n   (rst_n),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .adr     (adr),
    .dat_w   (dat_w),
    .sel     (sel),
    .dat_r   (dat_r),
    .ack     (ack),
    .req     (req),
    .hit     (hit),
    .rd_word (rd_word)
  );

  cache_core u_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .hit        (hit),
    .rd_word    (rd_word),
    .miss_start (miss_start),
    .miss       (miss),
    .line       (line),
    .fill       (fill),
    .fill_done  (fill_done)
  );

  burst_sequencer u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .miss_start    (miss_start),
    .miss          (miss),
    .line          (line),
    .cmd           (cmd),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .fill          (fill),
    .fill_done     (fill_done)
  );

endmodule

//--- verilog/burst_sequencer.sv
// miss FSM that evicts and fills cache lines over the burst RAM command port
`timescale 1ns/100ps
`include "cache_settings.svh"

module burst_sequencer
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        miss_start,
  input  miss_req_t   miss,
  input  line_data_t  line,
  output br_cmd_t     cmd,
  input  logic [63:0] rd_data,
  input  logic        rd_data_valid,
  output fill_beat_t  fill,
  output logic        fill_done
);

  localparam int unsigned CNT_BITS = $clog2(`CACHE_CMD_INTERVAL + 1);

  typedef enum logic [3:0] {
    S_IDLE,
    S_EVICT1,
    S_EVICT2,
    S_EVICT3,
    S_EVICT_FIN,
    S_WAIT_DATA,
    S_FILL1,
    S_FILL2,
    S_FILL3,
    S_FILL_FIN
  } state_e;

  state_e              state;
  logic [CNT_BITS-1:0] cnt;
  logic                armed;
  miss_req_t           miss_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      cnt       <= '0;
      armed     <= 1'b0;
      cmd.en    <= 1'b0;
      cmd.mask  <= '0;
      fill.we   <= 1'b0;
      fill_done <= 1'b0;
    end else begin
      // whole lines are written, nothing is masked
      cmd.mask <= '0;
      if (cnt != 0) begin
        cnt <= cnt - 1'b1;
      end

      if (miss_start) begin
        armed  <= 1'b1;
        miss_q <= miss;
      end

      case (state)
        S_IDLE: begin
          fill_done <= 1'b0;
          if (armed && cnt == 0) begin
            armed  <= 1'b0;
            cmd.en <= 1'b1;
            cnt    <= CNT_BITS'(`CACHE_CMD_INTERVAL);
            if (miss_q.dirty) begin
              // first write beat goes with the command
              cmd.we      <= 1'b1;
              cmd.addr    <= miss_q.victim_addr;
              cmd.wr_data <= {line[1], line[0]};
              state       <= S_EVICT1;
            end else begin
              cmd.we   <= 1'b0;
              cmd.addr <= miss_q.fill_addr;
              state    <= S_WAIT_DATA;
            end
          end
        end
        S_EVICT1: begin
          cmd.en      <= 1'b0;
          cmd.wr_data <= {line[3], line[2]};
          state       <= S_EVICT2;
        end
        S_EVICT2: begin
          cmd.wr_data <= {line[5], line[4]};
          state       <= S_EVICT3;
        end
        S_EVICT3: begin
          cmd.wr_data <= {line[7], line[6]};
          state       <= S_EVICT_FIN;
        end
        S_EVICT_FIN: begin
          // read of the new line once the interval has passed
          if (cnt == 0) begin
            cmd.en   <= 1'b1;
            cmd.we   <= 1'b0;
            cmd.addr <= miss_q.fill_addr;
            cnt      <= CNT_BITS'(`CACHE_CMD_INTERVAL);
            state    <= S_WAIT_DATA;
          end
        end
        S_WAIT_DATA: begin
          cmd.en <= 1'b0;
          if (rd_data_valid) begin
            fill.we   <= 1'b1;
            fill.idx  <= 2'd0;
            fill.data <= rd_data;
            state     <= S_FILL1;
          end
        end
        S_FILL1: begin
          fill.idx  <= 2'd1;
          fill.data <= rd_data;
          state     <= S_FILL2;
        end
        S_FILL2: begin
          fill.idx  <= 2'd2;
          fill.data <= rd_data;
          state     <= S_FILL3;
        end
        S_FILL3: begin
          fill.idx  <= 2'd3;
          fill.data <= rd_data;
          state     <= S_FILL_FIN;
        end
        S_FILL_FIN: begin
          // tag goes in one cycle after the last beat
          fill.we   <= 1'b0;
          fill_done <= 1'b1;
          state     <= S_IDLE;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

//--- verilog/cache_core.sv
// cache lookup core with tag and column storage, hit writes and line fills
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_core
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  cache_req_t  req,
  output logic        hit,
  output logic [31:0] rd_word,
  output logic        miss_start,
  output miss_req_t   miss,
  output line_data_t  line,
  input  fill_beat_t  fill,
  input  logic        fill_done
);

  localparam int unsigned IDX_BITS = `CACHE_LINE_INDEX_BITS;
  localparam int unsigned TAG_BITS = `CACHE_TAG_BITS;

  // address layout |tag|index|column|00|
  logic [TAG_BITS-1:0] req_tag;
  logic [IDX_BITS-1:0] req_idx;
  logic [2:0]          req_col;

  assign req_col = req.adr[4:2];
  assign req_idx = req.adr[IDX_BITS+4:5];
  assign req_tag = req.adr[TAG_BITS+IDX_BITS+4:IDX_BITS+5];

  tag_word_u   tag_rd;
  tag_word_u   tag_wr;
  logic        tag_we;
  logic [3:0]  col_we   [8];
  logic [31:0] col_din  [8];
  logic [31:0] col_dout [8];

  bram #(
    .addr_bits(IDX_BITS)
  ) u_tag (
    .clk  (clk),
    .we   ({4{tag_we}}),
    .addr (req_idx),
    .din  (tag_wr.raw),
    .dout (tag_rd.raw)
  );

  for (genvar i = 0; i < 8; i++) begin : g_col
    bram #(
      .addr_bits(IDX_BITS)
    ) u_col (
      .clk  (clk),
      .we   (col_we[i]),
      .addr (req_idx),
      .din  (col_din[i]),
      .dout (col_dout[i])
    );
  end

  // storage output belongs to the request once it was valid on the last edge
  logic look_q;
  logic match;
  logic miss_pend;

  assign match      = tag_rd.f.valid && (tag_rd.f.tag == req_tag);
  assign hit        = req.valid && look_q && match;
  assign miss_start = req.valid && look_q && !match && !miss_pend;
  assign rd_word    = col_dout[req_col];

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      line[i] = col_dout[i];
    end
    miss.dirty       = tag_rd.f.valid && tag_rd.f.dirty;
    miss.victim_addr = {tag_rd.f.tag, req_idx, 5'b0};
    miss.fill_addr   = {req_tag, req_idx, 5'b0};
  end

  // write steering, a fill has priority over the bus
  always_comb begin
    tag_we     = 1'b0;
    tag_wr.raw = '0;
    for (int i = 0; i < 8; i++) begin
      col_we[i]  = 4'b0000;
      col_din[i] = req.dat;
    end

    if (fill.we) begin
      // beat n lands in columns 2n and 2n+1
      for (int i = 0; i < 8; i++) begin
        if (i / 2 == int'(fill.idx)) begin
          col_we[i]  = 4'b1111;
          col_din[i] = (i % 2 == 1) ? fill.data[63:32] : fill.data[31:0];
        end
      end
    end else if (fill_done) begin
      tag_we         = 1'b1;
      tag_wr.f.valid = 1'b1;
      tag_wr.f.tag   = req_tag;
    end else if (hit && req.we) begin
      tag_we          = 1'b1;
      tag_wr.f.valid  = 1'b1;
      tag_wr.f.dirty  = 1'b1;
      tag_wr.f.tag    = req_tag;
      col_we[req_col] = req.sel;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      look_q    <= 1'b0;
      miss_pend <= 1'b0;
    end else begin
      look_q <= req.valid;
      // stays set until the refilled line reports a hit
      if (miss_start) begin
        miss_pend <= 1'b1;
      end else if (hit) begin
        miss_pend <= 1'b0;
      end
    end
  end

endmodule

//--- verilog/wb_cache_port.sv
// Wishbone classic slave that turns bus cycles into cache requests and acks
`timescale 1ns/100ps

module wb_cache_port
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [31:0] adr,
  input  logic [31:0] dat_w,
  input  logic [3:0]  sel,
  output logic [31:0] dat_r,
  output logic        ack,
  output cache_req_t  req,
  input  logic        hit,
  input  logic [31:0] rd_word
);

  // set with ack, keeps a held strobe from being served twice
  logic acked;

  always_comb begin
    req.valid = cyc && stb && !acked;
    req.we    = we;
    req.adr   = adr;
    req.dat   = dat_w;
    req.sel   = sel;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack   <= 1'b0;
      acked <= 1'b0;
    end else begin
      ack <= hit;
      if (!stb) begin
        acked <= 1'b0;
      end else if (hit) begin
        acked <= 1'b1;
      end
    end
  end

  // read word goes out together with ack
  always_ff @(posedge clk) begin
    if (hit) begin
      dat_r <= rd_word;
    end
  end

endmodule

//--- verilog/bram.sv
// single port block RAM with byte lane write enables and registered read
`timescale 1ns/100ps

module bram #(
  parameter int unsigned addr_bits = 4
) (
  input  logic                 clk,
  input  logic [3:0]           we,
  input  logic [addr_bits-1:0] addr,
  input  logic [31:0]          din,
  output logic [31:0]          dout
);

  logic [31:0] mem [2**addr_bits];

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (we[i]) begin
        mem[addr][8*i +: 8] <= din[8*i +: 8];
      end
    end
    // read returns the old word when the same address is written
    dout <= mem[addr];
  end

endmodule

//--- verilog/cache_pkg.sv
// cache types shared by the bus port, lookup core and burst sequencer
`include "cache_settings.svh"

package cache_pkg;

  // one Wishbone transfer as seen by the core
  typedef struct packed {
    logic        valid;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } cache_req_t;

  // tag store word, written raw and read back as fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [31-2-`CACHE_TAG_BITS:0] pad;
      logic                          dirty;
      logic                          valid;
      logic [`CACHE_TAG_BITS-1:0]    tag;
    } f;
  } tag_word_u;

  // the eight column words of one line
  typedef logic [7:0][31:0] line_data_t;

  // victim and fill line addresses of a miss
  typedef struct packed {
    logic                            dirty;
    logic [`CACHE_RAM_ADDR_BITS-1:0] victim_addr;
    logic [`CACHE_RAM_ADDR_BITS-1:0] fill_addr;
  } miss_req_t;

  // one 64 bit beat written into a column pair
  typedef struct packed {
    logic        we;
    logic [1:0]  idx;
    logic [63:0] data;
  } fill_beat_t;

  // burst RAM command port
  typedef struct packed {
    logic                            en;
    logic                            we;
    logic [`CACHE_RAM_ADDR_BITS-1:0] addr;
    logic [63:0]                     wr_data;
    logic [7:0]                      mask;
  } br_cmd_t;

endpackage

//--- verilog/cache_settings.svh
// cache sizing and burst RAM timing parameters shared by the cache blocks
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// number of line index bits, the cache holds 2 ** value lines
`define CACHE_LINE_INDEX_BITS 4

// width of the byte address of the burst RAM
`define CACHE_RAM_ADDR_BITS 21

// minimum cycles between two RAM commands, minus one
// the counter reloads on the command edge, so the spacing is value + 1
`define CACHE_CMD_INTERVAL 13

// tag bits left after line index, column index and byte offset
// 3 column bits + 2 byte bits below the line index
`define CACHE_TAG_BITS (`CACHE_RAM_ADDR_BITS - `CACHE_LINE_INDEX_BITS - 5)

`endif
